//--- src/leaf_defs.svh
`ifndef LEAF_DEFS_SVH
`define LEAF_DEFS_SVH

// packet field widths, valid bit sits on top
`define LEAF_PACKET_BITS  49
`define LEAF_PAYLOAD_BITS 32
`define LEAF_LEAF_BITS    5
`define LEAF_PORT_BITS    4
`define LEAF_ADDR_BITS    7

// leaf sizing
`define LEAF_NUM_OUT      6
`define LEAF_FIFO_DEPTH   4   // words per output channel

// destination port codes seen by the decoder
`define LEAF_CFG_PORT     0
`define LEAF_DATA_PORT    1

`endif

//--- src/leaf_pkg.sv
`include "leaf_defs.svh"

package leaf_pkg;

    typedef logic [`LEAF_PACKET_BITS-1:0]  packet_t;
    typedef logic [`LEAF_PAYLOAD_BITS-1:0] payload_t;
    typedef logic [`LEAF_LEAF_BITS-1:0]    leaf_id_t;
    typedef logic [`LEAF_PORT_BITS-1:0]    port_id_t;

    // channel index on config packets, sequence number on outgoing ones
    typedef logic [`LEAF_ADDR_BITS-1:0]    addr_t;

    typedef logic [$clog2(`LEAF_NUM_OUT + 1)-1:0] chan_sel_t;

    typedef enum logic {
        ARB_RUN,
        ARB_HOLD
    } arb_state_t;

endpackage

//--- src/leaf_decoder.sv
`timescale 1ns/1ns
`include "leaf_defs.svh"

module leaf_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  leaf_pkg::packet_t   din,
    output leaf_pkg::payload_t  user_rx_data,
    output logic                user_rx_vld,
    output logic                cfg_we,
    output leaf_pkg::chan_sel_t cfg_chan,
    output leaf_pkg::leaf_id_t  cfg_leaf,
    output leaf_pkg::port_id_t  cfg_port
);

    localparam int ADDR_LO = `LEAF_PAYLOAD_BITS;
    localparam int PORT_LO = ADDR_LO + `LEAF_ADDR_BITS;
    localparam int PORT_HI = PORT_LO + `LEAF_PORT_BITS - 1;

    logic               in_vld;
    leaf_pkg::port_id_t in_port;
    leaf_pkg::addr_t    in_addr;
    leaf_pkg::payload_t in_payload;
    logic               is_cfg;
    logic               is_data;

    // destination leaf of an arriving packet is already ours, so it is not looked at
    assign in_vld     = din[`LEAF_PACKET_BITS-1];
    assign in_port    = din[PORT_HI:PORT_LO];
    assign in_addr    = din[PORT_LO-1:ADDR_LO];
    assign in_payload = din[`LEAF_PAYLOAD_BITS-1:0];

    assign is_cfg  = in_vld && (in_port == leaf_pkg::port_id_t'(`LEAF_CFG_PORT));
    assign is_data = in_vld && (in_port == leaf_pkg::port_id_t'(`LEAF_DATA_PORT));

    // strobes, one cycle each
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_we      <= 1'b0;
            user_rx_vld <= 1'b0;
        end else begin
            cfg_we      <= is_cfg;
            user_rx_vld <= is_data;   // other ports fall through silently
        end
    end

    always_ff @(posedge clk) begin
        if (is_cfg) begin
            cfg_chan <= leaf_pkg::chan_sel_t'(in_addr);
            cfg_leaf <= in_payload[`LEAF_LEAF_BITS+`LEAF_PORT_BITS-1:`LEAF_PORT_BITS];
            cfg_port <= in_payload[`LEAF_PORT_BITS-1:0];
        end
        if (is_data) begin
            user_rx_data <= in_payload;
        end
    end

    // config packets must name a channel that exists, full 7-bit field checked
    a_cfg_chan_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        is_cfg |-> (in_addr >= 1 && in_addr <= `LEAF_NUM_OUT)
    );

endmodule

//--- src/out_channel.sv
`timescale 1ns/1ns
`include "leaf_defs.svh"

module out_channel #(
    parameter int CHAN_INDEX = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_we,
    input  leaf_pkg::chan_sel_t cfg_chan,
    input  leaf_pkg::leaf_id_t  cfg_leaf,
    input  leaf_pkg::port_id_t  cfg_port,
    input  leaf_pkg::payload_t  user_tx_data,
    input  logic                user_tx_vld,
    input  logic                chan_pop,
    output leaf_pkg::packet_t   chan_pkt,
    output logic                chan_ready
);

    localparam int PTR_BITS = $clog2(`LEAF_FIFO_DEPTH);
    localparam int CNT_BITS = $clog2(`LEAF_FIFO_DEPTH + 1);
    localparam int LAST_PTR = `LEAF_FIFO_DEPTH - 1;

    leaf_pkg::payload_t  fifo_mem [`LEAF_FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                fifo_full;
    logic                do_pop;
    logic                cfg_hit;

    leaf_pkg::leaf_id_t  dst_leaf;
    leaf_pkg::port_id_t  dst_port;
    leaf_pkg::addr_t     seq_num;

    assign cfg_hit    = cfg_we && (cfg_chan == leaf_pkg::chan_sel_t'(CHAN_INDEX));
    assign chan_ready = (count != '0);
    assign fifo_full  = (count == CNT_BITS'(`LEAF_FIFO_DEPTH));
    assign do_pop     = chan_pop && chan_ready;

    // destination of this channel, rewritten by config packets
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dst_leaf <= '0;
            dst_port <= '0;
        end else if (cfg_hit) begin
            dst_leaf <= cfg_leaf;
            dst_port <= cfg_port;
        end
    end

    always_ff @(posedge clk) begin
        if (user_tx_vld) begin
            fifo_mem[wr_ptr] <= user_tx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            seq_num <= '0;
        end else begin
            if (user_tx_vld) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(LAST_PTR)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr  <= (rd_ptr == PTR_BITS'(LAST_PTR)) ? '0 : rd_ptr + 1'b1;
                seq_num <= seq_num + 1'b1;   // wraps at 128
            end
            case ({user_tx_vld, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head word wrapped with our destination and sequence number
    assign chan_pkt = {chan_ready, dst_leaf, dst_port, seq_num, fifo_mem[rd_ptr]};

    // no back-pressure, the user has to respect the FIFO budget
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n)
        user_tx_vld |-> !fifo_full
    );

    // the arbiter only pops channels that offered a packet
    a_pop_when_ready : assert property (
        @(posedge clk) disable iff (!rst_n)
        chan_pop |-> chan_ready
    );

endmodule

//--- src/leaf_arbiter.sv
`timescale 1ns/1ns
`include "leaf_defs.svh"

module leaf_arbiter (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     resend,
    input  leaf_pkg::packet_t [`LEAF_NUM_OUT-1:0]    chan_pkt,
    input  logic              [`LEAF_NUM_OUT-1:0]    chan_ready,
    output logic              [`LEAF_NUM_OUT-1:0]    chan_pop,
    output leaf_pkg::packet_t                        dout
);

    leaf_pkg::arb_state_t state;
    leaf_pkg::chan_sel_t  last_win;   // 0-based index of the previous grant
    leaf_pkg::chan_sel_t  win;
    logic                 found;
    logic                 hold;
    leaf_pkg::packet_t    dout_q;

    // hold also covers one quiet cycle after resend drops
    assign hold = resend || (state == leaf_pkg::ARB_HOLD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= leaf_pkg::ARB_RUN;
        end else begin
            case (state)
                leaf_pkg::ARB_RUN:  if (resend)  state <= leaf_pkg::ARB_HOLD;
                leaf_pkg::ARB_HOLD: if (!resend) state <= leaf_pkg::ARB_RUN;
                default:            state <= leaf_pkg::ARB_RUN;
            endcase
        end
    end

    // search starts one past the last winner
    always_comb begin
        int idx;
        found = 1'b0;
        win   = last_win;
        for (int k = 1; k <= `LEAF_NUM_OUT; k++) begin
            idx = (int'(last_win) + k) % `LEAF_NUM_OUT;
            if (!found && chan_ready[idx]) begin
                found = 1'b1;
                win   = leaf_pkg::chan_sel_t'(idx);
            end
        end
    end

    always_comb begin
        chan_pop = '0;
        if (found && !hold) begin
            chan_pop[win] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_q   <= '0;
            last_win <= leaf_pkg::chan_sel_t'(`LEAF_NUM_OUT - 1);   // channel 0 goes first
        end else if (!hold) begin
            dout_q <= found ? chan_pkt[win] : '0;
            if (found) begin
                last_win <= win;
            end
        end
    end

    // a packet caught by resend stays in dout_q and goes out once the hold ends
    assign dout = hold ? '0 : dout_q;

    a_pop_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(chan_pop)
    );

endmodule

//--- src/leaf_node.sv
`timescale 1ns/1ns
`include "leaf_defs.svh"

module leaf_node (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    resend,
    input  leaf_pkg::packet_t                       din,
    input  leaf_pkg::payload_t [`LEAF_NUM_OUT-1:0]  user_tx_data,
    input  logic               [`LEAF_NUM_OUT-1:0]  user_tx_vld,
    output leaf_pkg::packet_t                       dout,
    output leaf_pkg::payload_t                      user_rx_data,
    output logic                                    user_rx_vld
);

    logic                                   cfg_we;
    leaf_pkg::chan_sel_t                    cfg_chan;
    leaf_pkg::leaf_id_t                     cfg_leaf;
    leaf_pkg::port_id_t                     cfg_port;

    leaf_pkg::packet_t [`LEAF_NUM_OUT-1:0]  chan_pkt;
    logic              [`LEAF_NUM_OUT-1:0]  chan_ready;
    logic              [`LEAF_NUM_OUT-1:0]  chan_pop;

    leaf_decoder u_leaf_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .din          (din),
        .user_rx_data (user_rx_data),
        .user_rx_vld  (user_rx_vld),
        .cfg_we       (cfg_we),
        .cfg_chan     (cfg_chan),
        .cfg_leaf     (cfg_leaf),
        .cfg_port     (cfg_port)
    );

    // channels are numbered from 1, matching the config address field
    for (genvar i = 0; i < `LEAF_NUM_OUT; i++) begin : g_chan
        out_channel #(
            .CHAN_INDEX (i + 1)
        ) u_out_channel (
            .clk          (clk),
            .rst_n        (rst_n),
            .cfg_we       (cfg_we),
            .cfg_chan     (cfg_chan),
            .cfg_leaf     (cfg_leaf),
            .cfg_port     (cfg_port),
            .user_tx_data (user_tx_data[i]),
            .user_tx_vld  (user_tx_vld[i]),
            .chan_pop     (chan_pop[i]),
            .chan_pkt     (chan_pkt[i]),
            .chan_ready   (chan_ready[i])
        );
    end

    leaf_arbiter u_leaf_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .resend     (resend),
        .chan_pkt   (chan_pkt),
        .chan_ready (chan_ready),
        .chan_pop   (chan_pop),
        .dout       (dout)
    );

endmodule

//--- verification/leaf_node_tb.sv
`timescale 1ns/1ns
`include "leaf_defs.svh"

module leaf_node_tb;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_STEPS       = 21;
    localparam int DRAIN_LIMIT     = 64;
    localparam int WATCHDOG_CYCLES = NUM_STEPS * 20 + 200;

    // packet layout, valid on top
    localparam int ADDR_LO   = `LEAF_PAYLOAD_BITS;
    localparam int PORT_LO   = ADDR_LO + `LEAF_ADDR_BITS;
    localparam int LEAF_LO   = PORT_LO + `LEAF_PORT_BITS;
    localparam int VALID_BIT = `LEAF_PACKET_BITS - 1;
    localparam int CFG_PAD   = `LEAF_PAYLOAD_BITS - `LEAF_LEAF_BITS - `LEAF_PORT_BITS;

    localparam logic [1:0] STEP_CFG  = 2'd0;
    localparam logic [1:0] STEP_DATA = 2'd1;
    localparam logic [1:0] STEP_PUSH = 2'd2;
    localparam int CH_ALL = 0;   // every channel in the same cycle
    localparam int CH_ROT = 7;   // one channel per cycle, rotating

    localparam leaf_pkg::leaf_id_t LOCAL_LEAF = 5'h03;

    typedef struct packed {
        logic [1:0] kind;
        logic [3:0] sel;          // channel for cfg and push, port for data
        logic [4:0] leaf;
        logic [3:0] port;
        logic [3:0] count;
        logic       under_resend;
    } step_t;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    resend;
    leaf_pkg::packet_t                       din;
    leaf_pkg::payload_t [`LEAF_NUM_OUT-1:0]  user_tx_data;
    logic               [`LEAF_NUM_OUT-1:0]  user_tx_vld;
    leaf_pkg::packet_t                       dout;
    leaf_pkg::payload_t                      user_rx_data;
    logic                                    user_rx_vld;

    step_t       step_tbl [NUM_STEPS];
    logic [31:0] lcg_state;

    // reference model: destinations, sequence counts, words still owed
    leaf_pkg::leaf_id_t exp_leaf [`LEAF_NUM_OUT];
    leaf_pkg::port_id_t exp_port [`LEAF_NUM_OUT];
    leaf_pkg::addr_t    exp_seq  [`LEAF_NUM_OUT];
    int                 exp_chan [$];   // channel tag of each owed word
    leaf_pkg::payload_t exp_word [$];
    leaf_pkg::payload_t rx_q [$];
    int                 pkt_stamp [$];  // monitor cycle of each matched packet

    bit mon_en;
    int cycle_cnt;
    int check_count;
    int mismatch_count;
    int error_count;

    leaf_node u_leaf_node (
        .clk          (clk),
        .rst_n        (rst_n),
        .resend       (resend),
        .din          (din),
        .user_tx_data (user_tx_data),
        .user_tx_vld  (user_tx_vld),
        .dout         (dout),
        .user_rx_data (user_rx_data),
        .user_rx_vld  (user_rx_vld)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic leaf_pkg::payload_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic step_t make_step(input logic [1:0] kind, input int sel, input int leaf,
                                        input int port, input int count, input bit rs);
        step_t st;
        st.kind         = kind;
        st.sel          = 4'(sel);
        st.leaf         = 5'(leaf);
        st.port         = 4'(port);
        st.count        = 4'(count);
        st.under_resend = rs;
        return st;
    endfunction

    function automatic logic [`LEAF_NUM_OUT-1:0] pick_channels(input int sel, input int r);
        if (sel == CH_ALL) return '1;
        if (sel == CH_ROT) return `LEAF_NUM_OUT'(1) << (r % `LEAF_NUM_OUT);
        return `LEAF_NUM_OUT'(1) << (sel - 1);
    endfunction

    task automatic load_table();
        for (int c = 1; c <= `LEAF_NUM_OUT; c++) begin
            step_tbl[c-1] = make_step(STEP_CFG, c, 'h10 + c, 'h2 + c, 0, 0);
        end
        step_tbl[6]  = make_step(STEP_DATA, 1, 0, 0, 0, 0);
        step_tbl[7]  = make_step(STEP_DATA, 2, 0, 0, 0, 0);
        step_tbl[8]  = make_step(STEP_DATA, 15, 0, 0, 0, 0);
        step_tbl[9]  = make_step(STEP_DATA, 1, 0, 0, 0, 0);
        step_tbl[10] = make_step(STEP_PUSH, 1, 0, 0, 1, 0);
        step_tbl[11] = make_step(STEP_PUSH, 3, 0, 0, 6, 0);
        step_tbl[12] = make_step(STEP_PUSH, 6, 0, 0, 3, 0);
        step_tbl[13] = make_step(STEP_PUSH, CH_ALL, 0, 0, 1, 0);
        step_tbl[14] = make_step(STEP_PUSH, CH_ALL, 0, 0, 2, 0);
        step_tbl[15] = make_step(STEP_PUSH, CH_ROT, 0, 0, 9, 1);
        step_tbl[16] = make_step(STEP_PUSH, 5, 0, 0, 4, 1);   // fills the FIFO exactly
        step_tbl[17] = make_step(STEP_DATA, 7, 0, 0, 0, 0);
        step_tbl[18] = make_step(STEP_CFG, 2, 'h1f, 'hf, 0, 0);
        step_tbl[19] = make_step(STEP_PUSH, 2, 0, 0, 3, 0);
        step_tbl[20] = make_step(STEP_PUSH, CH_ALL, 0, 0, 1, 0);
    endtask

    task automatic check_packet(input string name, input leaf_pkg::packet_t got,
                                input leaf_pkg::packet_t exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_word(input string name, input leaf_pkg::payload_t got,
                              input leaf_pkg::payload_t exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic take_packet(input leaf_pkg::packet_t pkt);
        int ch;
        int idx;
        leaf_pkg::packet_t exp;
        ch  = -1;
        idx = -1;
        for (int c = 0; c < `LEAF_NUM_OUT; c++) begin
            if (pkt[LEAF_LO +: `LEAF_LEAF_BITS] == exp_leaf[c] &&
                pkt[PORT_LO +: `LEAF_PORT_BITS] == exp_port[c]) ch = c;
        end
        for (int k = 0; k < exp_chan.size(); k++) begin
            if (idx < 0 && exp_chan[k] == ch) idx = k;
        end
        if (ch < 0) begin
            error_count++;
            $display("packet %h on dout has a destination no channel was given", pkt);
        end else if (idx < 0) begin
            error_count++;
            $display("packet %h from channel %0d was never pushed", pkt, ch + 1);
        end else begin
            exp = {1'b1, exp_leaf[ch], exp_port[ch], exp_seq[ch], exp_word[idx]};
            check_packet("dout", pkt, exp);
            exp_chan.delete(idx);
            exp_word.delete(idx);
            exp_seq[ch] = exp_seq[ch] + 1'b1;   // wraps with the address field
            pkt_stamp.push_back(cycle_cnt);
        end
    endtask

    // outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (mon_en) begin
            cycle_cnt++;
            if (resend) begin
                check_packet("dout", dout, '0);
            end else if (dout[VALID_BIT]) begin
                take_packet(dout);
            end else begin
                check_packet("dout", dout, '0);
            end
            if (user_rx_vld && rx_q.size() == 0) begin
                error_count++;
                $display("user word %h arrived with no data packet behind it", user_rx_data);
            end else if (user_rx_vld) begin
                check_word("user_rx_data", user_rx_data, rx_q.pop_front());
            end
        end
    end

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_chan.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_chan.size() != 0) begin
            error_count++;
            $display("%0d pushed words never left on dout", exp_chan.size());
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic run_cfg(input int ch, input leaf_pkg::leaf_id_t leaf,
                           input leaf_pkg::port_id_t port);
        @(posedge clk);
        din <= {1'b1, LOCAL_LEAF, leaf_pkg::port_id_t'(`LEAF_CFG_PORT),
                leaf_pkg::addr_t'(ch), {CFG_PAD{1'b0}}, leaf, port};
        @(posedge clk);
        din <= '0;
        exp_leaf[ch-1] = leaf;
        exp_port[ch-1] = port;
        repeat (3) @(posedge clk);   // decoder register, then channel register
    endtask

    task automatic run_data(input leaf_pkg::port_id_t port);
        leaf_pkg::payload_t word;
        word = lcg_next();
        @(posedge clk);
        din <= {1'b1, LOCAL_LEAF, port, leaf_pkg::addr_t'(0), word};
        @(posedge clk);
        din <= '0;
        if (port == `LEAF_DATA_PORT) rx_q.push_back(word);   // due in the cycle after this edge
        @(posedge clk);
        if (rx_q.size() != 0) begin
            error_count++;
            $display("user word %h missing one cycle after its data packet", rx_q[0]);
            rx_q.delete();
        end
    endtask

    task automatic check_burst(input int n0, input int n);
        int first;
        int last;
        if (pkt_stamp.size() != n0 + n) begin
            error_count++;
            $display("burst of %0d pushes gave %0d packets", n, pkt_stamp.size() - n0);
        end else begin
            first = pkt_stamp[n0];
            last  = pkt_stamp[n0 + n - 1];
            if (last - first != n - 1) begin
                error_count++;
                $display("burst packets spread over %0d cycles, expected %0d", last - first + 1, n);
            end
        end
    endtask

    task automatic run_push(input int sel, input int count, input bit under_resend);
        int n0;
        logic [`LEAF_NUM_OUT-1:0] mask;
        leaf_pkg::payload_t word;
        n0 = pkt_stamp.size();
        if (under_resend) begin
            @(posedge clk);
            resend <= 1'b1;
        end
        for (int r = 0; r < count; r++) begin
            @(posedge clk);
            mask = pick_channels(sel, r);
            for (int c = 0; c < `LEAF_NUM_OUT; c++) begin
                if (mask[c]) begin
                    word = lcg_next();
                    user_tx_data[c] <= word;
                    exp_chan.push_back(c);
                    exp_word.push_back(word);
                end
            end
            user_tx_vld <= mask;
        end
        @(posedge clk);
        user_tx_vld <= '0;
        if (under_resend) begin
            repeat (2) @(posedge clk);
            resend <= 1'b0;
        end
        wait_drain();
        if (sel == CH_ALL && !under_resend) check_burst(n0, count * `LEAF_NUM_OUT);
    endtask

    task automatic run_step(input step_t st);
        case (st.kind)
            STEP_CFG:  run_cfg(st.sel, st.leaf, st.port);
            STEP_DATA: run_data(st.sel);
            default:   run_push(st.sel, st.count, st.under_resend);
        endcase
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        resend         = 1'b0;
        din            = '0;
        user_tx_data   = '0;
        user_tx_vld    = '0;
        lcg_state      = 32'd24;
        mon_en         = 1'b0;
        cycle_cnt      = 0;
        check_count    = 0;
        mismatch_count = 0;
        error_count    = 0;
        for (int c = 0; c < `LEAF_NUM_OUT; c++) begin
            exp_leaf[c] = '0;
            exp_port[c] = '0;
            exp_seq[c]  = '0;
        end
        load_table();
        repeat (3) @(posedge clk);
        rst_n  <= 1'b1;
        mon_en = 1'b1;
        repeat (5) @(posedge clk);   // idle outputs must stay quiet
        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(step_tbl[i]);
        end
        wait_drain();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
src/leaf_pkg.sv
src/leaf_decoder.sv
src/out_channel.sv
src/leaf_arbiter.sv
src/leaf_node.sv
verification/leaf_node_tb.sv

//--- Bender.yml
package:
  name: leaf_node

sources:
  - include_dirs:
      - src
    files:
      - src/leaf_pkg.sv
      - src/leaf_decoder.sv
      - src/out_channel.sv
      - src/leaf_arbiter.sv
      - src/leaf_node.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/leaf_node_tb.sv
